// File: dcache_pkg.sv
// dcache shared types: op codes, request, tag, ram write, miss and refill structs, field helpers
`default_nettype none

package dcache_pkg;

  // widest way count the shared structs can carry
  localparam int MAX_WAY = 4;
  localparam int IDX_W = 8;
  localparam int TAG_W = 22;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_INV   = 2'd2
  } dcache_op_e;

  typedef enum logic [2:0] {
    MISS_STORE,
    MISS_REFILL,
    MISS_INV,
    MISS_UC_READ,
    MISS_UC_WRITE
  } miss_kind_e;

  typedef struct packed {
    logic        valid;
    dcache_op_e  op;
    logic        uncached;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strobe;
  } lsu_req_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } dcache_tag_t;

  typedef struct packed {
    logic [MAX_WAY-1:0] data_we;
    logic [IDX_W-1:0]   data_idx;
    logic [31:0]        data;
    logic [MAX_WAY-1:0] tag_we;
    logic [IDX_W-1:0]   tag_idx;
    dcache_tag_t        tag;
  } cache_wreq_t;

  typedef struct packed {
    logic               valid;
    miss_kind_e         kind;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    logic [3:0]         strobe;
    logic [MAX_WAY-1:0] hit_way;
    logic [31:0]        hit_line;
  } miss_req_t;

  typedef struct packed {
    logic        done;
    logic [31:0] rdata;
  } refill_state_t;

  function automatic logic [IDX_W-1:0] idx_of(input logic [31:0] addr);
    return addr[9:2];
  endfunction

  function automatic logic [TAG_W-1:0] tag_of(input logic [31:0] addr);
    return addr[31:10];
  endfunction

  // strobed bytes of new_word over old_word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strobe);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strobe[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

  // keeps strobed byte lanes in place, clears the rest
  function automatic logic [31:0] place_bytes(input logic [31:0] word,
                                              input logic [3:0]  strobe);
    logic [31:0] res;
    res = '0;
    for (int i = 0; i < 4; i++) begin
      if (strobe[i]) begin
        res[8*i +: 8] = word[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// File: dcache_ram.sv
// simple dual port ram, one write and one registered read port, generic payload
`timescale 1ns/1ps
`default_nettype none

module dcache_ram #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 256
) (
  input  wire logic                     clk,
  input  wire logic                     we_i,
  input  wire logic [$clog2(DEPTH)-1:0] waddr_i,
  input  wire payload_t                 wdata_i,
  input  wire logic [$clog2(DEPTH)-1:0] raddr_i,
  output payload_t                      rdata_o
);

  payload_t mem_q [DEPTH];

  // read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
    rdata_o <= mem_q[raddr_i];
  end

  a_waddr_range: assert property (@(posedge clk) we_i |-> (int'(waddr_i) < DEPTH));

endmodule

`default_nettype wire

// File: dcache_lookup.sv
// address and lookup stages: per-way tag and data rams, write forwarding, hit vector
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup #(
  parameter int WAY_CNT = 2
) (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire dcache_pkg::lsu_req_t           req_i,
  input  wire logic                           adv_i,
  input  wire dcache_pkg::cache_wreq_t        wreq_i,
  output dcache_pkg::lsu_req_t                lookup_o,
  output logic [WAY_CNT-1:0]                  hit_o,
  output logic [WAY_CNT-1:0][31:0]            line_o,
  output dcache_pkg::dcache_tag_t [WAY_CNT-1:0] tag_o
);

  localparam int DEPTH = 1 << dcache_pkg::IDX_W;

  dcache_pkg::lsu_req_t                 addr_q;
  dcache_pkg::lsu_req_t                 lookup_q;
  dcache_pkg::cache_wreq_t              wreq_q;
  logic                                 adv_q;
  logic [dcache_pkg::IDX_W-1:0]         raddr;
  logic [dcache_pkg::IDX_W-1:0]         look_idx;
  logic [WAY_CNT-1:0][31:0]             raw_data;
  logic [WAY_CNT-1:0][31:0]             data_copy_q;
  logic [WAY_CNT-1:0][31:0]             data_fwd;
  dcache_pkg::dcache_tag_t [WAY_CNT-1:0] raw_tag;
  dcache_pkg::dcache_tag_t [WAY_CNT-1:0] tag_copy_q;
  dcache_pkg::dcache_tag_t [WAY_CNT-1:0] tag_fwd;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_q.valid   <= 1'b0;
      lookup_q.valid <= 1'b0;
      wreq_q         <= '0;
      adv_q          <= 1'b0;
    end else begin
      if (adv_i) begin
        addr_q   <= req_i;
        lookup_q <= addr_q;
      end
      wreq_q <= wreq_i;
      adv_q  <= adv_i;
    end
  end

  // held copy keeps the lookup view while the address stage re-reads
  always_ff @(posedge clk) begin
    data_copy_q <= data_fwd;
    tag_copy_q  <= tag_fwd;
  end

  assign raddr    = dcache_pkg::idx_of(addr_q.addr);
  assign look_idx = dcache_pkg::idx_of(lookup_q.addr);

  for (genvar w = 0; w < WAY_CNT; w++) begin : g_way
    dcache_ram #(
      .payload_t(logic [31:0]),
      .DEPTH    (DEPTH)
    ) i_data_ram (
      .clk    (clk),
      .we_i   (wreq_i.data_we[w]),
      .waddr_i(wreq_i.data_idx),
      .wdata_i(wreq_i.data),
      .raddr_i(raddr),
      .rdata_o(raw_data[w])
    );

    dcache_ram #(
      .payload_t(dcache_pkg::dcache_tag_t),
      .DEPTH    (DEPTH)
    ) i_tag_ram (
      .clk    (clk),
      .we_i   (wreq_i.tag_we[w]),
      .waddr_i(wreq_i.tag_idx),
      .wdata_i(wreq_i.tag),
      .raddr_i(raddr),
      .rdata_o(raw_tag[w])
    );

    // older write first, current write wins
    always_comb begin
      data_fwd[w] = adv_q ? raw_data[w] : data_copy_q[w];
      tag_fwd[w]  = adv_q ? raw_tag[w] : tag_copy_q[w];
      if (wreq_q.data_we[w] && wreq_q.data_idx == look_idx) begin
        data_fwd[w] = wreq_q.data;
      end
      if (wreq_q.tag_we[w] && wreq_q.tag_idx == look_idx) begin
        tag_fwd[w] = wreq_q.tag;
      end
      if (wreq_i.data_we[w] && wreq_i.data_idx == look_idx) begin
        data_fwd[w] = wreq_i.data;
      end
      if (wreq_i.tag_we[w] && wreq_i.tag_idx == look_idx) begin
        tag_fwd[w] = wreq_i.tag;
      end
    end

    assign hit_o[w] = lookup_q.valid && !lookup_q.uncached && tag_fwd[w].valid &&
                      tag_fwd[w].tag == dcache_pkg::tag_of(lookup_q.addr);
  end

  assign lookup_o = lookup_q;
  assign line_o   = data_fwd;
  assign tag_o    = tag_fwd;

  // a tag lives in at most one way of a set
  a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hit_o));

endmodule

`default_nettype wire

// File: dcache_resp.sv
// response stage: miss and uncached fsm, result select, read formatting, miss request
`timescale 1ns/1ps
`default_nettype none

module dcache_resp #(
  parameter int WAY_CNT = 2
) (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire dcache_pkg::lsu_req_t             lookup_i,
  input  wire logic [WAY_CNT-1:0]               hit_i,
  input  wire logic [WAY_CNT-1:0][31:0]         line_i,
  input  wire dcache_pkg::dcache_tag_t [WAY_CNT-1:0] tag_i,
  input  wire dcache_pkg::refill_state_t        refill_i,
  output dcache_pkg::miss_req_t                 miss_o,
  output logic                                  busy_o,
  output logic                                  adv_o,
  output logic                                  rsp_valid_o,
  output logic [31:0]                           rsp_rdata_o
);

  typedef enum logic [1:0] {NORMAL, WAIT_MEM, WAIT_INIT, DONE} state_e;

  state_e                                state_q;
  dcache_pkg::lsu_req_t                  resp_q;
  logic [WAY_CNT-1:0]                    hit_q;
  logic [WAY_CNT-1:0][31:0]              line_q;
  dcache_pkg::dcache_tag_t [WAY_CNT-1:0] tag_q;
  logic                                  tag_dup;
  logic [31:0]                           rdata_q;
  logic [31:0]                           sel_line;
  logic                                  hit_any;
  logic                                  need_miss;
  dcache_pkg::miss_kind_e                kind;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_q.valid <= 1'b0;
    end else if (adv_o) begin
      resp_q <= lookup_i;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_o) begin
      hit_q  <= hit_i;
      line_q <= line_i;
      tag_q  <= tag_i;
    end
    if (state_q == WAIT_MEM && refill_i.done) begin
      rdata_q <= refill_i.rdata;
    end
  end

  assign hit_any = |hit_q;

  always_comb begin
    sel_line = '0;
    for (int w = 0; w < WAY_CNT; w++) begin
      if (hit_q[w]) begin
        sel_line = sel_line | line_q[w];
      end
    end
  end

  // store miss goes straight to memory, no allocate
  always_comb begin
    need_miss = 1'b0;
    kind      = dcache_pkg::MISS_REFILL;
    if (resp_q.valid) begin
      if (resp_q.uncached) begin
        need_miss = resp_q.op != dcache_pkg::OP_INV;
        kind      = (resp_q.op == dcache_pkg::OP_READ) ? dcache_pkg::MISS_UC_READ
                                                       : dcache_pkg::MISS_UC_WRITE;
      end else if (resp_q.op == dcache_pkg::OP_READ) begin
        need_miss = !hit_any;
      end else if (resp_q.op == dcache_pkg::OP_WRITE) begin
        need_miss = 1'b1;
        kind      = hit_any ? dcache_pkg::MISS_STORE : dcache_pkg::MISS_UC_WRITE;
      end else begin
        need_miss = hit_any;
        kind      = dcache_pkg::MISS_INV;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= WAIT_INIT;
    end else begin
      case (state_q)
        NORMAL:    if (need_miss) state_q <= WAIT_MEM;
        WAIT_MEM:  if (refill_i.done) state_q <= DONE;
        WAIT_INIT: if (refill_i.done) state_q <= NORMAL;
        default:   state_q <= NORMAL;
      endcase
    end
  end

  assign busy_o = (state_q == NORMAL && need_miss) || state_q == WAIT_MEM ||
                  state_q == WAIT_INIT;
  assign adv_o  = !busy_o;

  assign rsp_valid_o = resp_q.valid && resp_q.op == dcache_pkg::OP_READ &&
                       ((state_q == NORMAL && !resp_q.uncached && hit_any) ||
                        state_q == DONE);
  assign rsp_rdata_o = dcache_pkg::place_bytes(state_q == DONE ? rdata_q : sel_line,
                                               resp_q.strobe);

  always_comb begin
    miss_o                  = '0;
    miss_o.valid            = state_q == NORMAL && need_miss;
    miss_o.kind             = kind;
    miss_o.addr             = resp_q.addr;
    miss_o.wdata            = resp_q.wdata;
    miss_o.strobe           = resp_q.strobe;
    miss_o.hit_way[WAY_CNT-1:0] = hit_q;
    miss_o.hit_line         = sel_line;
  end

  // two valid ways of one set holding the same tag
  always_comb begin
    tag_dup = 1'b0;
    for (int w = 0; w < WAY_CNT; w++) begin
      for (int v = w + 1; v < WAY_CNT; v++) begin
        if (tag_q[w].valid && tag_q[v].valid && tag_q[w].tag == tag_q[v].tag) begin
          tag_dup = 1'b1;
        end
      end
    end
  end

  a_no_rsp_busy: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o |-> !busy_o);
  // refills only allocate on a miss, so a set never holds a tag twice
  a_tag_unique: assert property (@(posedge clk) disable iff (!rst_n)
    resp_q.valid |-> !tag_dup);

endmodule

`default_nettype wire

// File: dcache_refill.sv
// ram write port and memory port: tag init, store hits, refills, invalidates, uncached access
`timescale 1ns/1ps
`default_nettype none

module dcache_refill #(
  parameter int WAY_CNT = 2
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire dcache_pkg::miss_req_t     miss_i,
  output dcache_pkg::refill_state_t      state_o,
  output dcache_pkg::cache_wreq_t        wreq_o,
  output logic                           init_busy_o,
  output logic                           mem_req_o,
  output logic                           mem_we_o,
  output logic [31:0]                    mem_addr_o,
  output logic [31:0]                    mem_wdata_o,
  output logic [3:0]                     mem_strobe_o,
  input  wire logic                      mem_ack_i,
  input  wire logic [31:0]               mem_rdata_i
);

  typedef enum logic [2:0] {S_INIT, S_IDLE, S_ISSUE, S_WAIT, S_FINISH} state_e;

  state_e                         state_q;
  dcache_pkg::miss_req_t          req_q;
  logic [dcache_pkg::IDX_W-1:0]   cnt_q;
  logic [1:0]                     victim_q;
  logic [31:0]                    rdata_q;
  logic                           outstanding_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q       <= S_INIT;
      cnt_q         <= '0;
      victim_q      <= '0;
      outstanding_q <= 1'b0;
    end else begin
      case (state_q)
        S_INIT: begin
          cnt_q <= cnt_q + 1'b1;
          if (&cnt_q) state_q <= S_IDLE;
        end
        S_IDLE: begin
          if (miss_i.valid) begin
            state_q <= (miss_i.kind == dcache_pkg::MISS_INV) ? S_FINISH : S_ISSUE;
          end
        end
        S_ISSUE: state_q <= S_WAIT;
        S_WAIT:  if (mem_ack_i) state_q <= S_FINISH;
        default: begin
          state_q <= S_IDLE;
          // one round-robin pointer for the whole cache
          if (req_q.kind == dcache_pkg::MISS_REFILL) begin
            victim_q <= (victim_q == 2'(WAY_CNT - 1)) ? 2'd0 : victim_q + 2'd1;
          end
        end
      endcase
      if (mem_req_o) begin
        outstanding_q <= 1'b1;
      end else if (mem_ack_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && miss_i.valid) begin
      req_q <= miss_i;
    end
    if (state_q == S_WAIT && mem_ack_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign init_busy_o   = state_q == S_INIT;
  assign state_o.done  = state_q == S_FINISH || (state_q == S_INIT && &cnt_q);
  assign state_o.rdata = rdata_q;

  assign mem_req_o    = state_q == S_ISSUE;
  assign mem_we_o     = req_q.kind == dcache_pkg::MISS_STORE ||
                        req_q.kind == dcache_pkg::MISS_UC_WRITE;
  assign mem_addr_o   = req_q.addr;
  assign mem_wdata_o  = req_q.wdata;
  assign mem_strobe_o = mem_we_o ? req_q.strobe : 4'hf;

  // every ram write leaves from here
  always_comb begin
    wreq_o          = '0;
    wreq_o.data_idx = dcache_pkg::idx_of(req_q.addr);
    wreq_o.tag_idx  = dcache_pkg::idx_of(req_q.addr);
    if (state_q == S_INIT) begin
      wreq_o.tag_idx = cnt_q;
      wreq_o.tag_we[WAY_CNT-1:0] = '1;
    end else if (state_q == S_FINISH) begin
      case (req_q.kind)
        dcache_pkg::MISS_REFILL: begin
          for (int w = 0; w < WAY_CNT; w++) begin
            wreq_o.data_we[w] = victim_q == 2'(w);
            wreq_o.tag_we[w]  = victim_q == 2'(w);
          end
          wreq_o.data      = rdata_q;
          wreq_o.tag.valid = 1'b1;
          wreq_o.tag.tag   = dcache_pkg::tag_of(req_q.addr);
        end
        dcache_pkg::MISS_STORE: begin
          wreq_o.data_we[WAY_CNT-1:0] = req_q.hit_way[WAY_CNT-1:0];
          wreq_o.data = dcache_pkg::merge_bytes(req_q.hit_line, req_q.wdata, req_q.strobe);
        end
        dcache_pkg::MISS_INV: wreq_o.tag_we[WAY_CNT-1:0] = req_q.hit_way[WAY_CNT-1:0];
        default: ;
      endcase
    end
  end

  a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o |-> !outstanding_q);

endmodule

`default_nettype wire

// File: dcache_top.sv
// dcache top level: lookup, response and refill units wired together
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
  parameter int WAY_CNT = 2
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire dcache_pkg::lsu_req_t  req_i,
  output logic                       busy_o,
  output logic                       rsp_valid_o,
  output logic [31:0]                rsp_rdata_o,
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output logic [31:0]                mem_addr_o,
  output logic [31:0]                mem_wdata_o,
  output logic [3:0]                 mem_strobe_o,
  input  wire logic                  mem_ack_i,
  input  wire logic [31:0]           mem_rdata_i
);

  logic                                  adv;
  logic                                  resp_busy;
  logic                                  init_busy;
  dcache_pkg::lsu_req_t                  lookup_q;
  logic [WAY_CNT-1:0]                    hit;
  logic [WAY_CNT-1:0][31:0]              line;
  dcache_pkg::dcache_tag_t [WAY_CNT-1:0] tag;
  dcache_pkg::miss_req_t                 miss_req;
  dcache_pkg::refill_state_t             refill_state;
  dcache_pkg::cache_wreq_t               wreq;

  assign busy_o = resp_busy | init_busy;

  dcache_lookup #(.WAY_CNT(WAY_CNT)) i_lookup (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (req_i),
    .adv_i   (adv),
    .wreq_i  (wreq),
    .lookup_o(lookup_q),
    .hit_o   (hit),
    .line_o  (line),
    .tag_o   (tag)
  );

  dcache_resp #(.WAY_CNT(WAY_CNT)) i_resp (
    .clk        (clk),
    .rst_n      (rst_n),
    .lookup_i   (lookup_q),
    .hit_i      (hit),
    .line_i     (line),
    .tag_i      (tag),
    .refill_i   (refill_state),
    .miss_o     (miss_req),
    .busy_o     (resp_busy),
    .adv_o      (adv),
    .rsp_valid_o(rsp_valid_o),
    .rsp_rdata_o(rsp_rdata_o)
  );

  dcache_refill #(.WAY_CNT(WAY_CNT)) i_refill (
    .clk         (clk),
    .rst_n       (rst_n),
    .miss_i      (miss_req),
    .state_o     (refill_state),
    .wreq_o      (wreq),
    .init_busy_o (init_busy),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_strobe_o(mem_strobe_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

endmodule

`default_nettype wire

// File: tb_dcache.sv
// dcache testbench with memory model, lfsr stimulus, reference reads, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

  localparam int REQ_TOTAL = 36;
  // reset, tag init and a per-request budget
  localparam int TIMEOUT_CYCLES = 5 + 256 + 40 * REQ_TOTAL;

  logic                 clk = 1'b0;
  logic                 rst_n;
  dcache_pkg::lsu_req_t req_i;
  logic                 busy_o;
  logic                 rsp_valid_o;
  logic [31:0]          rsp_rdata_o;
  logic                 mem_req_o;
  logic                 mem_we_o;
  logic [31:0]          mem_addr_o;
  logic [31:0]          mem_wdata_o;
  logic [3:0]           mem_strobe_o;
  logic                 mem_ack_i;
  logic [31:0]          mem_rdata_i;

  // backing memory, and the word the core should read back
  logic [31:0] mem_model [1024];
  logic [31:0] ref_mem [1024];

  logic [31:0] exp_q [$];
  string       name_q [$];
  logic [31:0] lfsr_q;
  string       cur_test;
  int          errors;
  int          checks;
  int          rsp_errors;
  int          rsp_checks;
  int          mem_errors;
  int          tests;
  int          err_base;
  int          req_cnt;
  int          cycle_cnt = 0;

  logic        m_we;
  logic [9:0]  m_widx;
  logic [31:0] m_wdata;
  logic [3:0]  m_strobe;
  logic [31:0] m_delay;
  logic [31:0] exp_word;
  string       exp_name;

  dcache_top #(.WAY_CNT(2)) i_dcache_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_strobe_o(mem_strobe_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

  always #10 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits = {bits[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] lane_mask(input logic [3:0] strobe);
    return {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
  endfunction

  // lanes outside the strobe read as zero
  function automatic logic [31:0] expected_read(input logic [31:0] addr,
                                                input logic [3:0]  strobe,
                                                input logic        uc);
    logic [31:0] word;
    word = uc ? mem_model[addr[11:2]] : ref_mem[addr[11:2]];
    return word & lane_mask(strobe);
  endfunction

  function automatic int total_errors();
    return errors + rsp_errors + mem_errors;
  endfunction

  task automatic issue_req(input dcache_pkg::dcache_op_e op, input logic uc,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strobe);
    dcache_pkg::lsu_req_t req;
    logic                 taken;
    req.valid    = 1'b1;
    req.op       = op;
    req.uncached = uc;
    req.addr     = addr;
    req.wdata    = wdata;
    req.strobe   = strobe;
    req_i <= req;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = busy_o === 1'b0;
      @(posedge clk);
    end
    // taken on this edge, so the reference follows program order
    if (op == dcache_pkg::OP_READ) begin
      exp_q.push_back(expected_read(addr, strobe, uc));
      name_q.push_back(cur_test);
    end else if (op == dcache_pkg::OP_WRITE) begin
      ref_mem[addr[11:2]] = (ref_mem[addr[11:2]] & ~lane_mask(strobe)) |
                            (wdata & lane_mask(strobe));
    end else if (!uc) begin
      // an invalidated word refetches what memory holds
      ref_mem[addr[11:2]] = mem_model[addr[11:2]];
    end
  endtask

  // idle input until three stages have emptied
  task automatic drain_pipe();
    int idle_cnt;
    req_i <= '0;
    idle_cnt = 0;
    while (idle_cnt < 4) begin
      @(negedge clk);
      if (busy_o === 1'b0) begin
        idle_cnt++;
      end else begin
        idle_cnt = 0;
      end
      @(posedge clk);
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d read responses never arrived", cur_test, exp_q.size());
      errors += exp_q.size();
      exp_q.delete();
      name_q.delete();
    end
  endtask

  task automatic open_test(input string name);
    cur_test = name;
    err_base = total_errors();
  endtask

  task automatic close_test();
    tests++;
    if (total_errors() == err_base) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: FAILED with %0d errors", cur_test, total_errors() - err_base);
    end
  endtask

  task automatic compare_count(input string what, input int exp, input int act);
    checks++;
    if (act != exp) begin
      $display("Mismatch %s %s: expected %0d actual %0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic init_wait();
    int busy_cycles;
    open_test("init");
    busy_cycles = 0;
    @(negedge clk);
    while (busy_o === 1'b1) begin
      busy_cycles++;
      @(negedge clk);
    end
    compare_count("busy cycles", 256, busy_cycles);
    @(posedge clk);
    close_test();
  endtask

  task automatic cold_miss();
    int base;
    open_test("cold_miss");
    base = req_cnt;
    issue_req(dcache_pkg::OP_READ, 1'b0, 32'h0000_0040, 32'h0, 4'hf);
    issue_req(dcache_pkg::OP_READ, 1'b0, 32'h0000_0040, 32'h0, 4'hf);
    drain_pipe();
    compare_count("mem_req pulses", 1, req_cnt - base);
    close_test();
  endtask

  task automatic read_burst();
    logic [31:0] addrs [8];
    logic [31:0] bits;
    int          base;
    open_test("read_burst");
    for (int i = 0; i < 8; i++) begin
      take_bits(2, bits);
      // distinct sets, random tag within the model
      addrs[i] = {20'h0, bits[1:0], 8'(i * 17 + 3), 2'b00};
    end
    for (int i = 0; i < 8; i++) begin
      issue_req(dcache_pkg::OP_READ, 1'b0, addrs[i], 32'h0, 4'hf);
    end
    drain_pipe();
    base = req_cnt;
    for (int i = 0; i < 8; i++) begin
      take_bits(4, bits);
      issue_req(dcache_pkg::OP_READ, 1'b0, addrs[i], 32'h0, bits[3:0]);
    end
    drain_pipe();
    compare_count("mem_req pulses on hits", 0, req_cnt - base);
    close_test();
  endtask

  task automatic store_forward();
    logic [31:0] addr;
    logic [31:0] wdata;
    int          base;
    open_test("store_forward");
    addr  = 32'h0000_00c0;
    wdata = ~ref_mem[addr[11:2]];
    base  = req_cnt;
    issue_req(dcache_pkg::OP_READ, 1'b0, addr, 32'h0, 4'hf);
    issue_req(dcache_pkg::OP_WRITE, 1'b0, addr, wdata, 4'b0110);
    issue_req(dcache_pkg::OP_READ, 1'b0, addr, 32'h0, 4'hf);
    drain_pipe();
    checks++;
    if (mem_model[addr[11:2]] !== ref_mem[addr[11:2]]) begin
      $display("Mismatch %s memory word: expected %h actual %h", cur_test,
               ref_mem[addr[11:2]], mem_model[addr[11:2]]);
      errors++;
    end
    compare_count("mem_req pulses", 2, req_cnt - base);
    close_test();
  endtask

  task automatic set_conflict();
    logic [31:0] x0;
    logic [31:0] x1;
    logic [31:0] x2;
    int          base;
    open_test("set_conflict");
    // set 0xa0 under three tags
    x0 = 32'h0000_0280;
    x1 = 32'h0000_0680;
    x2 = 32'h0000_0a80;
    issue_req(dcache_pkg::OP_READ, 1'b0, x0, 32'h0, 4'hf);
    issue_req(dcache_pkg::OP_READ, 1'b0, x1, 32'h0, 4'hf);
    drain_pipe();
    base = req_cnt;
    repeat (2) begin
      issue_req(dcache_pkg::OP_READ, 1'b0, x0, 32'h0, 4'hf);
      issue_req(dcache_pkg::OP_READ, 1'b0, x1, 32'h0, 4'hf);
    end
    drain_pipe();
    compare_count("mem_req pulses while resident", 0, req_cnt - base);
    issue_req(dcache_pkg::OP_READ, 1'b0, x2, 32'h0, 4'hf);
    issue_req(dcache_pkg::OP_READ, 1'b0, x0, 32'h0, 4'hf);
    issue_req(dcache_pkg::OP_READ, 1'b0, x1, 32'h0, 4'hf);
    issue_req(dcache_pkg::OP_READ, 1'b0, x2, 32'h0, 4'hf);
    drain_pipe();
    close_test();
  endtask

  task automatic backdoor_inv();
    logic [31:0] addr;
    int          base;
    open_test("backdoor_inv");
    addr = 32'h0000_0320;
    issue_req(dcache_pkg::OP_READ, 1'b0, addr, 32'h0, 4'hf);
    drain_pipe();
    // memory changes behind the cache
    mem_model[addr[11:2]] = ~mem_model[addr[11:2]] ^ 32'h0101_0101;
    issue_req(dcache_pkg::OP_READ, 1'b1, addr, 32'h0, 4'hf);
    issue_req(dcache_pkg::OP_READ, 1'b0, addr, 32'h0, 4'hf);
    drain_pipe();
    base = req_cnt;
    issue_req(dcache_pkg::OP_INV, 1'b0, addr, 32'h0, 4'hf);
    issue_req(dcache_pkg::OP_READ, 1'b0, addr, 32'h0, 4'hf);
    drain_pipe();
    compare_count("mem_req pulses after invalidate", 1, req_cnt - base);
    close_test();
  endtask

  // memory model, answers after 1 to 8 cycles
  initial begin
    mem_ack_i   <= 1'b0;
    mem_rdata_i <= '0;
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && mem_req_o === 1'b1) begin
        if (mem_addr_o[31:12] != 20'h0) begin
          $display("memory request to %h lies outside the 4 KB model", mem_addr_o);
          mem_errors++;
        end
        m_we     = mem_we_o;
        m_widx   = mem_addr_o[11:2];
        m_wdata  = mem_wdata_o;
        m_strobe = mem_strobe_o;
        take_bits(3, m_delay);
        repeat (int'(m_delay) + 1) @(posedge clk);
        if (m_we) begin
          mem_model[m_widx] = (mem_model[m_widx] & ~lane_mask(m_strobe)) |
                              (m_wdata & lane_mask(m_strobe));
        end
        mem_rdata_i <= mem_model[m_widx];
        mem_ack_i   <= 1'b1;
        @(posedge clk);
        mem_ack_i   <= 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n === 1'b1 && mem_req_o === 1'b1) begin
      req_cnt++;
    end
  end

  always @(negedge clk) begin
    if (rst_n === 1'b1 && rsp_valid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("%s: read response %h arrived with no read outstanding",
                 cur_test, rsp_rdata_o);
        rsp_errors++;
      end else begin
        exp_word = exp_q.pop_front();
        exp_name = name_q.pop_front();
        rsp_checks++;
        if (rsp_rdata_o !== exp_word) begin
          $display("Mismatch %s: expected %h actual %h", exp_name, exp_word, rsp_rdata_o);
          rsp_errors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles in test %s", cycle_cnt, cur_test);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    rst_n  <= 1'b0;
    req_i  <= '0;
    lfsr_q = 32'h3396;
    cur_test = "reset";
    errors = 0;
    checks = 0;
    rsp_errors = 0;
    rsp_checks = 0;
    mem_errors = 0;
    tests = 0;
    req_cnt = 0;
    for (int i = 0; i < 1024; i++) begin
      // hash of the whole word index
      mem_model[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h0bad_f00d;
      ref_mem[i]   = mem_model[i];
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    init_wait();
    cold_miss();
    read_burst();
    store_forward();
    set_conflict();
    backdoor_inv();
    $display("tests %0d, checks %0d, errors %0d", tests, checks + rsp_checks,
             total_errors());
    if (total_errors() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dcache_top.f
dcache_pkg.sv
dcache_ram.sv
dcache_lookup.sv
dcache_resp.sv
dcache_refill.sv
dcache_top.sv
tb_dcache.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_dcache
RTL_TOP  := dcache_top
FILELIST := dcache_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
